// ==== filelist.f ====
hdl/BackendPkg.sv
hdl/CtrlUnitBackend.sv
hdl/PipeStageReg.sv
hdl/RenameAlloc.sv
hdl/IssueQueue.sv
hdl/ExecPipe.sv
hdl/ReorderBuffer.sv
hdl/BackendTop.sv
test/BackendTb.sv

// ==== hdl/BackendPkg.sv ====
package BackendPkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes and latencies
    //////////////////////////////////////////////////////////////////////

    localparam int ROB_DEPTH = 8;
    localparam int ROB_IDX_W = 3;
    localparam int NUM_PHYS  = 12;      // Physical tags handed out by rename
    localparam int TAG_W     = 4;
    localparam int IQ_DEPTH  = 4;
    localparam int IQ_PTR_W  = 2;
    localparam int ID_W      = 8;

    localparam int ALU_LAT   = 1;
    localparam int LSU_LAT   = 2;
    localparam int MDU_LAT   = 3;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_ALU = 2'd0,
        OP_LSU = 2'd1,
        OP_MDU = 2'd2
    } opClass_t;

    typedef struct packed {
        logic            valid;
        logic [ID_W-1:0] id;
        opClass_t        opClass;
        logic            excFlag;      // Raises a backend flush when it commits
    } inst_t;

    typedef struct packed {
        inst_t                inst;
        logic [TAG_W-1:0]     tag;
        logic [ROB_IDX_W-1:0] robIdx;
    } renamed_t;

    // Request from a stage up to the control unit
    typedef struct packed {
        logic pauseReq;
        logic flushReq;
    } ctrlReq_t;

    typedef struct packed {
        logic pause;
        logic flush;
    } ctrlCmd_t;

    typedef struct packed {
        logic             valid;
        logic [ID_W-1:0]  id;
        logic [TAG_W-1:0] tag;
        logic             excFlag;
    } commit_t;

endpackage

// ==== hdl/BackendTop.sv ====
module BackendTop (
    input  logic                clk,
    input  logic                reset,
    input  BackendPkg::inst_t   inst,
    output logic                inStall,
    output BackendPkg::commit_t commit,
    output logic                flushOut
);
    import BackendPkg::*;

    inst_t                decodeOut;
    inst_t                renameOut;
    renamed_t             dispatchData;
    ctrlReq_t             robReq;
    ctrlCmd_t             decodeCtrl;
    ctrlCmd_t             renameCtrl;
    ctrlCmd_t             robCtrl;
    ctrlCmd_t             iqCtrl;
    ctrlCmd_t             execCtrl;
    logic                 renameRecover;
    logic                 pauseRename;
    logic                 renameAllocatable;
    logic                 dispatch;
    logic [TAG_W-1:0]     allocTag;
    logic [ROB_IDX_W-1:0] allocIdx;
    logic                 aluPush, lsuPush, mduPush;
    logic                 aluReady, lsuReady, mduReady;
    logic                 aluIssue, lsuIssue, mduIssue;
    logic [ROB_IDX_W-1:0] aluIssueIdx, lsuIssueIdx, mduIssueIdx;
    logic                 aluDone, lsuDone, mduDone;
    logic [ROB_IDX_W-1:0] aluDoneIdx, lsuDoneIdx, mduDoneIdx;

    assign inStall  = decodeCtrl.pause || decodeCtrl.flush;
    assign flushOut = robReq.flushReq;

    //////////////////////////////////////////////////////////////////////
    // Decode, rename and dispatch
    //////////////////////////////////////////////////////////////////////

    PipeStageReg i_decodeReg (.clk, .reset, .ctrl(decodeCtrl), .in(inst), .out(decodeOut));
    PipeStageReg i_renameReg (.clk, .reset, .ctrl(renameCtrl), .in(decodeOut), .out(renameOut));

    // Tag and ROB slot are taken as the instruction leaves the rename register
    assign dispatch     = renameOut.valid && !pauseRename;
    assign dispatchData = '{inst: renameOut, tag: allocTag, robIdx: allocIdx};
    assign aluPush      = dispatch && renameOut.opClass == OP_ALU;
    assign lsuPush      = dispatch && renameOut.opClass == OP_LSU;
    assign mduPush      = dispatch && renameOut.opClass == OP_MDU;

    RenameAlloc i_renameAlloc (
        .clk, .reset, .alloc(dispatch), .recover(renameRecover), .commit,
        .tag(allocTag), .renameAllocatable
    );

    IssueQueue i_aluIQ (.clk, .reset, .ctrl(iqCtrl), .push(aluPush), .pushData(dispatchData),
                        .ready(aluReady), .issue(aluIssue), .issueIdx(aluIssueIdx));
    IssueQueue i_lsuIQ (.clk, .reset, .ctrl(iqCtrl), .push(lsuPush), .pushData(dispatchData),
                        .ready(lsuReady), .issue(lsuIssue), .issueIdx(lsuIssueIdx));
    IssueQueue i_mduIQ (.clk, .reset, .ctrl(iqCtrl), .push(mduPush), .pushData(dispatchData),
                        .ready(mduReady), .issue(mduIssue), .issueIdx(mduIssueIdx));

    ExecPipe #(.LATENCY(ALU_LAT)) i_aluPipe (.clk, .reset, .flush(execCtrl.flush),
        .start(aluIssue), .startIdx(aluIssueIdx), .done(aluDone), .doneIdx(aluDoneIdx));
    ExecPipe #(.LATENCY(LSU_LAT)) i_lsuPipe (.clk, .reset, .flush(execCtrl.flush),
        .start(lsuIssue), .startIdx(lsuIssueIdx), .done(lsuDone), .doneIdx(lsuDoneIdx));
    ExecPipe #(.LATENCY(MDU_LAT)) i_mduPipe (.clk, .reset, .flush(execCtrl.flush),
        .start(mduIssue), .startIdx(mduIssueIdx), .done(mduDone), .doneIdx(mduDoneIdx));

    ReorderBuffer i_rob (
        .clk, .reset, .ctrl(robCtrl), .alloc(dispatch), .allocInst(renameOut),
        .allocTag, .allocIdx,
        .aluDone, .aluDoneIdx, .lsuDone, .lsuDoneIdx, .mduDone, .mduDoneIdx,
        .req(robReq), .commit
    );

    // The ROB doubles as the commit stage, so both requests come from it
    CtrlUnitBackend i_ctrlUnit (
        .robReq, .commitReq(robReq),
        .aluIQReady(aluReady), .lsuIQReady(lsuReady), .mduIQReady(mduReady),
        .renameAllocatable,
        .decodeCtrl, .renameCtrl, .robCtrl, .iqCtrl, .execCtrl,
        .renameRecover, .pauseRename
    );

endmodule

// ==== hdl/CtrlUnitBackend.sv ====
module CtrlUnitBackend (
    input  BackendPkg::ctrlReq_t robReq,
    input  BackendPkg::ctrlReq_t commitReq,
    input  logic                 aluIQReady,
    input  logic                 lsuIQReady,
    input  logic                 mduIQReady,
    input  logic                 renameAllocatable,
    output BackendPkg::ctrlCmd_t decodeCtrl,
    output BackendPkg::ctrlCmd_t renameCtrl,
    output BackendPkg::ctrlCmd_t robCtrl,
    output BackendPkg::ctrlCmd_t iqCtrl,
    output BackendPkg::ctrlCmd_t execCtrl,
    output logic                 renameRecover,
    output logic                 pauseRename
);

    // Anything that blocks dispatch also blocks rename
    assign pauseRename =
        robReq.pauseReq ||
        !aluIQReady     ||
        !lsuIQReady     ||
        !mduIQReady;

    // The decode register must also wait for a free physical tag
    assign decodeCtrl.pause =
        robReq.pauseReq ||
        !aluIQReady     ||
        !lsuIQReady     ||
        !mduIQReady     ||
        !renameAllocatable;

    assign renameCtrl.pause = pauseRename;
    assign robCtrl.pause    = 1'b0;
    assign iqCtrl.pause     = 1'b0;     // Pipes are fully pipelined so queues never wait
    assign execCtrl.pause   = 1'b0;

    //////////////////////////////////////////////////////////////////////
    // Commit flush goes to everything at once
    //////////////////////////////////////////////////////////////////////

    assign decodeCtrl.flush = commitReq.flushReq;
    assign renameCtrl.flush = commitReq.flushReq;
    assign robCtrl.flush    = commitReq.flushReq;
    assign iqCtrl.flush     = commitReq.flushReq;
    assign execCtrl.flush   = commitReq.flushReq;
    assign renameRecover    = commitReq.flushReq;

endmodule

// ==== hdl/ExecPipe.sv ====
module ExecPipe #(
    parameter int LATENCY = BackendPkg::ALU_LAT
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                flush,
    input  logic                                start,
    input  logic [BackendPkg::ROB_IDX_W-1:0]    startIdx,
    output logic                                done,
    output logic [BackendPkg::ROB_IDX_W-1:0]    doneIdx
);
    import BackendPkg::*;

    logic [LATENCY-1:0]   validChain;
    logic [ROB_IDX_W-1:0] idxChain [LATENCY];

    assign done    = validChain[LATENCY-1];
    assign doneIdx = idxChain[LATENCY-1];

    // One slot per cycle of latency, so a new op can enter every cycle
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            validChain <= '0;
        end else begin
            validChain[0] <= start;
            for (int i = 1; i < LATENCY; i++) begin
                validChain[i] <= validChain[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        idxChain[0] <= startIdx;
        for (int i = 1; i < LATENCY; i++) begin
            idxChain[i] <= idxChain[i-1];
        end
    end

endmodule

// ==== hdl/IssueQueue.sv ====
module IssueQueue (
    input  logic                                clk,
    input  logic                                reset,
    input  BackendPkg::ctrlCmd_t                ctrl,
    input  logic                                push,
    input  BackendPkg::renamed_t                pushData,
    output logic                                ready,
    output logic                                issue,
    output logic [BackendPkg::ROB_IDX_W-1:0]    issueIdx
);
    import BackendPkg::*;

    renamed_t            mem [IQ_DEPTH];
    logic [IQ_PTR_W-1:0] head;
    logic [IQ_PTR_W-1:0] tail;
    logic [IQ_PTR_W:0]   count;

    assign ready    = count != (IQ_PTR_W + 1)'(IQ_DEPTH);
    assign issue    = (count != '0) && !ctrl.pause;   // Head leaves every cycle it exists
    assign issueIdx = mem[head].robIdx;

    always_ff @(posedge clk) begin
        if (reset || ctrl.flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= tail + 1'b1;
            if (issue) head <= head + 1'b1;
            case ({push, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= pushData;
        end
    end

    // The control unit pauses dispatch whenever any queue is full
    noPushWhenFull: assert property (
        @(posedge clk) disable iff (reset) push |-> ready
    );

endmodule

// ==== hdl/PipeStageReg.sv ====
module PipeStageReg (
    input  logic                 clk,
    input  logic                 reset,
    input  BackendPkg::ctrlCmd_t ctrl,
    input  BackendPkg::inst_t    in,
    output BackendPkg::inst_t    out
);

    // Flush beats pause so a stalled stage still empties on an exception
    always_ff @(posedge clk) begin
        if (reset || ctrl.flush) begin
            out.valid <= 1'b0;
        end else if (!ctrl.pause) begin
            out.valid <= in.valid;
        end
        if (!ctrl.pause) begin
            out.id      <= in.id;
            out.opClass <= in.opClass;
            out.excFlag <= in.excFlag;
        end
    end

endmodule

// ==== hdl/RenameAlloc.sv ====
module RenameAlloc (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            alloc,
    input  logic                            recover,
    input  BackendPkg::commit_t             commit,
    output logic [BackendPkg::TAG_W-1:0]    tag,
    output logic                            renameAllocatable
);
    import BackendPkg::*;

    logic [TAG_W-1:0] tagPtr;
    logic [TAG_W-1:0] freeCount;

    assign tag               = tagPtr;
    assign renameAllocatable = freeCount != '0;

    // After a full flush no tag is held by live work, so everything is free
    always_ff @(posedge clk) begin
        if (reset || recover) begin
            tagPtr    <= '0;
            freeCount <= TAG_W'(NUM_PHYS);
        end else begin
            if (alloc) begin
                if (tagPtr == TAG_W'(NUM_PHYS - 1)) tagPtr <= '0;
                else tagPtr <= tagPtr + 1'b1;
            end
            case ({alloc, commit.valid})
                2'b10:   freeCount <= freeCount - 1'b1;
                2'b01:   freeCount <= freeCount + 1'b1;   // Commit releases its tag
                default: freeCount <= freeCount;
            endcase
        end
    end

    // Dispatch is only gated by pauseRename, so the tag supply must never run dry
    allocOnlyWhenFree: assert property (
        @(posedge clk) disable iff (reset) alloc && !recover |-> renameAllocatable
    );

endmodule

// ==== hdl/ReorderBuffer.sv ====
module ReorderBuffer (
    input  logic                                clk,
    input  logic                                reset,
    input  BackendPkg::ctrlCmd_t                ctrl,
    input  logic                                alloc,
    input  BackendPkg::inst_t                   allocInst,
    input  logic [BackendPkg::TAG_W-1:0]        allocTag,
    output logic [BackendPkg::ROB_IDX_W-1:0]    allocIdx,
    input  logic                                aluDone,
    input  logic [BackendPkg::ROB_IDX_W-1:0]    aluDoneIdx,
    input  logic                                lsuDone,
    input  logic [BackendPkg::ROB_IDX_W-1:0]    lsuDoneIdx,
    input  logic                                mduDone,
    input  logic [BackendPkg::ROB_IDX_W-1:0]    mduDoneIdx,
    output BackendPkg::ctrlReq_t                req,
    output BackendPkg::commit_t                 commit
);
    import BackendPkg::*;

    inst_t                entryInst [ROB_DEPTH];
    logic [TAG_W-1:0]     entryTag  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] doneVec;
    logic [ROB_IDX_W-1:0] head;
    logic [ROB_IDX_W-1:0] tail;
    logic [ROB_IDX_W:0]   count;
    logic                 full;
    logic                 commitFire;
    logic                 commitValid;
    inst_t                commitInst;
    logic [TAG_W-1:0]     commitTag;
    logic                 flushReg;

    assign full     = count == (ROB_IDX_W + 1)'(ROB_DEPTH);
    assign allocIdx = tail;
    assign req      = '{pauseReq: full, flushReq: flushReg};
    assign commit   = '{valid: commitValid, id: commitInst.id, tag: commitTag,
                        excFlag: commitInst.excFlag};

    // Nothing younger than an exception may commit before the flush arrives
    assign commitFire = (count != '0) && doneVec[head] && !ctrl.pause &&
                        !(commitValid && commitInst.excFlag);

    //////////////////////////////////////////////////////////////////////
    // Pointers, done bits and the commit strobe
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || ctrl.flush) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            doneVec     <= '0;
            commitValid <= 1'b0;
        end else begin
            if (alloc) begin
                tail          <= tail + 1'b1;
                doneVec[tail] <= 1'b0;
            end
            if (aluDone) doneVec[aluDoneIdx] <= 1'b1;
            if (lsuDone) doneVec[lsuDoneIdx] <= 1'b1;
            if (mduDone) doneVec[mduDoneIdx] <= 1'b1;
            if (commitFire) head <= head + 1'b1;
            case ({alloc, commitFire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            commitValid <= commitFire;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entryInst[tail] <= allocInst;
            entryTag[tail]  <= allocTag;
        end
        if (commitFire) begin
            commitInst <= entryInst[head];
            commitTag  <= entryTag[head];
        end
    end

    // Flush follows the exception commit by one cycle
    always_ff @(posedge clk) begin
        if (reset) flushReg <= 1'b0;
        else flushReg <= commitValid && commitInst.excFlag;
    end

    noAllocWhenFull: assert property (
        @(posedge clk) disable iff (reset) alloc |-> !full
    );

    singleCycleFlush: assert property (
        @(posedge clk) disable iff (reset) req.flushReq |=> !req.flushReq
    );

endmodule

// ==== test/BackendTb.sv ====
module BackendTb;
    import BackendPkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int RAND_CYCLES    = 300;
    localparam int BURST_CYCLES   = 60;
    localparam int STIM_CYCLES    = RAND_CYCLES + BURST_CYCLES;
    localparam int TIMEOUT_CYCLES = 40 * STIM_CYCLES;

    logic    clk;
    logic    reset;
    inst_t   inst;
    logic    inStall;
    commit_t commit;
    logic    flushOut;

    commit_t          modelQ [$];     // Accepted instructions still waiting to commit
    logic [TAG_W-1:0] nextTag;
    logic [ID_W-1:0]  nextId;
    logic             lastAccepted;
    logic             prevExc;
    int               commitErrors;
    int               flushErrors;
    int               resetErrors;
    int               otherErrors;
    int               cycleCount;

    BackendTop i_dut (.clk, .reset, .inst, .inStall, .commit, .flushOut);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkCommit(input commit_t expected, input commit_t actual);
        if (actual !== expected) begin
            commitErrors++;
            $display("CHECK FAILED commit: expected id 0x%h tag 0x%h excFlag 0x%h, %s",
                     expected.id, expected.tag, expected.excFlag, "see next line");
            $display("    got valid 0x%h id 0x%h tag 0x%h excFlag 0x%h",
                     actual.valid, actual.id, actual.tag, actual.excFlag);
        end
    endtask

    // Flush must follow an exception commit by exactly one cycle
    task automatic checkFlush(input logic lastExc, input logic seen);
        if (seen !== lastExc) begin
            flushErrors++;
            $display("CHECK FAILED flushOut: expected 0x%h got 0x%h", lastExc, seen);
        end
    endtask

    task automatic expectLowAfterReset(input string name, input logic actual);
        if (actual !== 1'b0) begin
            resetErrors++;
            $display("CHECK FAILED %s after reset: expected 0x0 got 0x%h", name, actual);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic inst_t randomInst(input logic mduOnly);
        inst_t pick;
        pick.id = nextId;
        if (mduOnly) begin
            pick.valid   = 1'b1;
            pick.opClass = OP_MDU;
            pick.excFlag = 1'b0;
        end else begin
            pick.valid   = ($urandom % 10) < 7;
            pick.opClass = opClass_t'($urandom % 3);
            pick.excFlag = ($urandom % 16) == 0;   // Roughly one exception in 16
        end
        return pick;
    endfunction

    // A stalled instruction is held until the backend takes it
    task automatic runStimulus(input int cycles, input logic mduOnly);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            if (!inst.valid || lastAccepted) inst = randomInst(mduOnly);
        end
    endtask

    task automatic drainIdle();
        @(posedge clk);
        #1;
        inst = '0;
        while (modelQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);             // Leaves room for a trailing flush
    endtask

    //////////////////////////////////////////////////////////////////////
    // Model and monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        commit_t expected;
        if (reset) begin
            modelQ.delete();
            nextTag      = '0;
            nextId       = '0;
            prevExc      = 1'b0;
            lastAccepted = 1'b0;
        end else begin
            checkFlush(prevExc, flushOut);
            prevExc = 1'b0;
            if (commit.valid) begin
                if (modelQ.size() == 0) begin
                    otherErrors++;
                    $display("Commit of id 0x%h arrived with nothing accepted and pending",
                             commit.id);
                end else begin
                    expected = modelQ.pop_front();
                    checkCommit(expected, commit);
                    prevExc = expected.excFlag;
                end
            end
            if (flushOut) begin
                modelQ.delete();              // Everything younger than the exception is gone
                nextTag = '0;
            end
            lastAccepted = inst.valid && !inStall;
            if (lastAccepted) begin
                expected = '{valid: 1'b1, id: inst.id, tag: nextTag, excFlag: inst.excFlag};
                modelQ.push_back(expected);
                nextTag = (nextTag == TAG_W'(NUM_PHYS - 1)) ? '0 : nextTag + 1'b1;
                nextId  = nextId + 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, accepted instructions never committed",
                     cycleCount);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h49f6_63cb));
        commitErrors = 0;
        flushErrors  = 0;
        resetErrors  = 0;
        otherErrors  = 0;
        cycleCount   = 0;
        nextId       = '0;
        nextTag      = '0;
        prevExc      = 1'b0;
        lastAccepted = 1'b0;
        inst         = '0;
        reset        = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        expectLowAfterReset("commit.valid", commit.valid);
        expectLowAfterReset("flushOut", flushOut);
        expectLowAfterReset("inStall", inStall);

        runStimulus(RAND_CYCLES, 1'b0);
        drainIdle();
        runStimulus(BURST_CYCLES, 1'b1);       // Long MDU run with no exceptions
        drainIdle();

        $display("Error counts: commit %0d, flush %0d, reset %0d, other %0d",
                 commitErrors, flushErrors, resetErrors, otherErrors);
        if (commitErrors + flushErrors + resetErrors + otherErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
